// File: flist.f
common/mipsPkg.sv
common/ctrlIf.sv
execute/regFile.sv
execute/alu.sv
execute/dataMemory.sv
execute/executeUnit.sv
src/controlDecoder.sv
src/fetchUnit.sv
src/cpuTop.sv
bench/cpuTop_props.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from sim.log
verilator --binary --timing --assert --top-module cpuTb -f flist.f -o cpuSim \
    && { ./obj_dir/cpuSim +verilator+error+limit+100 > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Simulation FAILED" sim.log \
    && grep -q "Simulation PASSED" sim.log \
    || { echo "Run failed, see sim.log"; exit 1; }

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import mipsPkg::*; ();

    logic        Clk;
    logic        reset;
    logic        enable;
    logic [31:0] instr;
    logic [31:0] pcAddr;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;

    logic [31:0] lfsrState;
    logic [31:0] prog [$];         // Assembled program, one word per entry
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];
    logic [31:0] modelPc;
    logic [31:0] endAddr;
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic        expStore;
    logic        programReady = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          watchdogNs;
    int          i;

    cpuTop uut (.*);

    bind cpuTop cpuTop_props props (.*);

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
        return {opRType, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] functFor(input logic [2:0] sel);
        case (sel)
            3'd0:    return fnAdd;
            3'd1:    return fnSub;
            3'd2:    return fnAnd;
            3'd3:    return fnOr;
            3'd4:    return fnXor;
            3'd5:    return fnSll;
            3'd6:    return fnSrl;
            default: return fnMul;
        endcase
    endfunction

    // Instruction responder, answers outside the program with a nop
    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        if ($isunknown(addr) || (addr >> 2) >= prog.size()) return 32'd0;
        return prog[addr >> 2];
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic buildProgram();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [5:0]  idx;
        int          k;
        int          p;
        emit(encI(opAddi, 5'd0, 5'd1, 16'(takeBits(16))));
        for (k = 0; k < 4; k++) begin    // Immediate stores through a base register
            emit(encI(opAddi, 5'd0, 5'd2, 16'(takeBits(16))));
            emit(encI(opAddi, 5'd0, 5'd3, 16'(takeBits(16))));
            emit(encI(opSw, 5'd3, 5'd2, 16'(takeBits(16))));
        end
        for (k = 0; k < 16; k++) begin   // Every ALU op once, then random picks
            emit(encI(opAddi, 5'd0, 5'd4, 16'(takeBits(16))));
            emit(encI(opAddi, 5'd0, 5'd5, 16'(takeBits(16))));
            emit(encR(functFor(k < 8 ? 3'(k) : 3'(takeBits(3))), 5'd4, 5'd5, 5'd6));
            emit(encI(opSw, 5'd0, 5'd6, {8'd0, 6'(takeBits(6)), 2'b00}));
        end
        emit(encR(fnAdd, 5'd4, 5'd5, 5'd0));
        emit(encI(opSw, 5'd0, 5'd0, 16'(takeBits(16))));
        for (k = 0; k < 4; k++) begin    // Store, load back, store elsewhere
            idx = 6'(takeBits(6));
            emit(encI(opAddi, 5'd0, 5'd7, 16'(takeBits(16))));
            emit(encI(opSw, 5'd0, 5'd7, {8'd0, idx, 2'b00}));
            emit(encI(opLw, 5'd0, 5'd8, {8'd0, idx, 2'b00}));
            emit(encI(opSw, 5'd0, 5'd8, {8'd0, idx + 6'd1, 2'b00}));
        end
        for (k = 0; k < 6; k++) begin
            immA = 16'(takeBits(16));
            immB = (takeBits(1) != 32'd0) ? immA : immA + 16'd1;  // Equal means taken
            emit(encI(opAddi, 5'd0, 5'd9, immA));
            emit(encI(opAddi, 5'd0, 5'd10, immB));
            emit(encI(opBeq, 5'd9, 5'd10, 16'd2));
            emit(encI(opAddi, 5'd0, 5'd11, 16'(takeBits(16))));
            emit(encI(opSw, 5'd0, 5'd11, 16'(takeBits(16))));
            emit(encI(opSw, 5'd0, 5'd9, 16'(takeBits(16))));
        end
        for (k = 0; k < 3; k++) begin
            p = prog.size();
            emit({opJal, 26'(p + 3)});
            emit(encI(opAddi, 5'd0, 5'd12, 16'(takeBits(16))));  // Runs after the return
            emit(encI(opBeq, 5'd0, 5'd0, 16'd2));                // Hop over the subroutine
            emit(encI(opSw, 5'd0, 5'd31, 16'(takeBits(16))));
            emit(encR(fnJr, 5'd31, 5'd0, 5'd0));
        end
        emit(encI(opSw, 5'd0, 5'd12, 16'(takeBits(16))));
    endtask

    // Reference model of one executed instruction
    task automatic stepModel(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immExt;
        logic [31:0] addr;
        logic [31:0] pcNext;
        a = modelRegs[w[25:21]];
        b = modelRegs[w[20:16]];
        immExt = {{16{w[15]}}, w[15:0]};
        addr = a + immExt;
        pcNext = modelPc + 32'd4;
        case (w[31:26])
            opRType: begin
                case (w[5:0])
                    fnAdd:   modelRegs[w[15:11]] = a + b;
                    fnSub:   modelRegs[w[15:11]] = a - b;
                    fnAnd:   modelRegs[w[15:11]] = a & b;
                    fnOr:    modelRegs[w[15:11]] = a | b;
                    fnXor:   modelRegs[w[15:11]] = a ^ b;
                    fnSll:   modelRegs[w[15:11]] = a << b[4:0];
                    fnSrl:   modelRegs[w[15:11]] = a >> b[4:0];
                    fnMul:   modelRegs[w[15:11]] = a * b;
                    fnJr:    pcNext = a;
                    default: ;
                endcase
            end
            opLw:   modelRegs[w[20:16]] = modelMem[addr[7:2]];
            opSw:   modelMem[addr[7:2]] = b;
            opBeq:  pcNext = (a == b) ? modelPc + 32'd4 + {immExt[29:0], 2'b00} : pcNext;
            opAddi: modelRegs[w[20:16]] = addr;
            opJal: begin
                modelRegs[31] = modelPc + 32'd4;
                pcNext = {pcNext[31:28], w[25:0], 2'b00};
            end
            default: ;
        endcase
        modelRegs[0] = '0;
        modelPc = pcNext;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    initial begin
        wait (programReady);
        #(watchdogNs);
        $display("Watchdog timeout: the program did not reach its end");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        instr = '0;
        lfsrState = 32'h0b32_d985;
        modelPc = '0;
        for (i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        buildProgram();
        endAddr = prog.size() * 4;
        watchdogNs = prog.size() * 80 + 160;  // Two periods per word plus reset
        programReady = 1'b1;
        repeat (3) begin
            @(negedge Clk);
            enable = 1'b1;
            instr = encI(opSw, 5'd0, 5'd0, 16'd0);  // A store held during reset
            #10;
            checkValue("pcAddr", 32'd0, pcAddr);
            checkValue("memWe", 32'd0, {31'd0, memWe});
        end
        @(negedge Clk);
        reset = 1'b0;                 // Fourth rising edge saw reset high
        while (modelPc < endAddr) begin
            enable = (takeBits(3) != 32'd0);  // Roughly one stall in eight
            instr = wordAt(pcAddr);
            expStore = enable && (instr[31:26] == opSw);
            expAddr = modelRegs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]};
            expData = modelRegs[instr[20:16]];
            #10;
            checkValue("pcAddr", modelPc, pcAddr);
            checkValue("memWe", {31'd0, expStore}, {31'd0, memWe});
            if (expStore) begin
                checkValue("memAddr", expAddr, memAddr);
                checkValue("memWdata", expData, memWdata);
            end
            if (enable) begin
                stepModel(instr);
            end
            @(negedge Clk);
        end
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.props.failCount);
        if ((errors == 0) && (uut.props.failCount == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bench/cpuTop_props.sv
`timescale 1ns/1ps

module cpuTop_props import mipsPkg::*; (
    input logic                 Clk,
    input logic                 reset,
    input logic                 enable,
    input logic [dataWidth-1:0] instr,
    input logic [dataWidth-1:0] pcAddr,
    input logic                 memWe
);

    instrWord instrU;
    logic     isControl;
    int       failCount = 0;  // Failed assertion attempts

    assign instrU = instr;
    assign isControl = (instrU.r.opcode == opBeq) || (instrU.r.opcode == opJal)
                    || ((instrU.r.opcode == opRType) && (instrU.r.funct == fnJr));

    noStoreInReset: assert property (@(posedge Clk) reset |-> !memWe)
        else begin
            failCount++;
            $error("memWe high while reset is held");
        end

    // First edge after reset still stores nothing
    pcAfterReset: assert property (@(posedge Clk) $past(reset) |-> (pcAddr == '0) && !memWe)
        else begin
            failCount++;
            $error("pcAddr not cleared or memWe high after reset");
        end

    seqStep: assert property (@(posedge Clk) disable iff (reset)
        enable && !isControl |=> pcAddr == $past(pcAddr) + 32'd4)
        else begin
            failCount++;
            $error("pcAddr did not advance by 4");
        end

    stallHold: assert property (@(posedge Clk) disable iff (reset)
        !enable |=> pcAddr == $past(pcAddr))
        else begin
            failCount++;
            $error("pcAddr moved during a stall");
        end

    stallNoStore: assert property (@(posedge Clk) !enable |-> !memWe)
        else begin
            failCount++;
            $error("memWe high during a stall");
        end

endmodule

// File: src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import mipsPkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [dataWidth-1:0] instr,
    output logic [dataWidth-1:0] pcAddr,
    output logic                 memWe,
    output logic [dataWidth-1:0] memAddr,
    output logic [dataWidth-1:0] memWdata
);

    instrWord             instrU;     // Same word, viewed by field
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic                 aluZero;
    logic [dataWidth-1:0] rsValue;
    logic                 dmemWe;
    logic [dataWidth-1:0] dmemAddr;
    logic [dataWidth-1:0] dmemWdata;
    logic [dataWidth-1:0] dmemRdata;

    assign instrU = instr;

    ctrlIf ctrl ();

    controlDecoder decoder (
        .instr (instrU),
        .enable(enable),
        .reset (reset),
        .ctrl  (ctrl.decoder)
    );

    fetchUnit fetch (
        .Clk    (Clk),
        .reset  (reset),
        .enable (enable),
        .instr  (instrU),
        .ctrl   (ctrl.fetch),
        .aluZero(aluZero),
        .rsValue(rsValue),
        .pc     (pc),
        .pcPlus4(pcPlus4)
    );

    executeUnit execute (
        .Clk     (Clk),
        .instr   (instrU),
        .ctrl    (ctrl.execute),
        .pcPlus4 (pcPlus4),
        .memRdata(dmemRdata),
        .aluZero (aluZero),
        .rsValue (rsValue),
        .memWe   (dmemWe),
        .memAddr (dmemAddr),
        .memWdata(dmemWdata)
    );

    dataMemory dmem (
        .Clk      (Clk),
        .writeEn  (dmemWe),
        .addr     (dmemAddr),
        .writeData(dmemWdata),
        .readData (dmemRdata)
    );

    assign pcAddr   = pc;
    assign memWe    = dmemWe;
    assign memAddr  = dmemAddr;
    assign memWdata = dmemWdata;

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 enable,
    input  instrWord             instr,
    ctrlIf.fetch                 ctrl,
    input  logic                 aluZero,
    input  logic [dataWidth-1:0] rsValue,
    output logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] pcPlus4
);

    logic [dataWidth-1:0] branchOffset;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] jalTarget;
    logic [dataWidth-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Word offset, sign extended and scaled to bytes
    assign branchOffset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;
    assign jalTarget    = {pcPlus4[31:28], instr.j.target, 2'b00};  // Stays in the current region

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsValue;
        end else if (ctrl.jump) begin
            nextPc = jalTarget;
        end else if (ctrl.branch && aluZero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
        end else if (enable) begin  // Low enable stalls the core
            pc <= nextPc;
        end
    end

endmodule

// File: src/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
    input  instrWord instr,
    input  logic     enable,
    input  logic     reset,
    ctrlIf.decoder   ctrl
);

    logic regWriteRaw;
    logic memWriteRaw;

    always_comb begin
        // Defaults describe a no-write operation
        regWriteRaw   = 1'b0;
        memWriteRaw   = 1'b0;
        ctrl.regDst   = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.aluOp    = aluAdd;

        case (instr.r.opcode)
            opRType: begin
                ctrl.regDst = 1'b1;
                regWriteRaw = 1'b1;
                case (instr.r.funct)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr:  ctrl.aluOp = aluOr;
                    fnXor: ctrl.aluOp = aluXor;
                    fnSll: ctrl.aluOp = aluSll;
                    fnSrl: ctrl.aluOp = aluSrl;
                    fnMul: ctrl.aluOp = aluMul;
                    fnJr: begin
                        regWriteRaw  = 1'b0;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: regWriteRaw = 1'b0;  // Unknown funct does nothing
                endcase
            end
            opLw: begin
                regWriteRaw   = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opSw: begin
                memWriteRaw = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;  // Equal operands give a zero result
            end
            opAddi: begin
                regWriteRaw = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opJal: begin
                regWriteRaw = 1'b1;
                ctrl.jump   = 1'b1;
            end
            default: ;
        endcase
    end

    // Stall or reset suppresses every state change outside the PC
    assign ctrl.regWrite = regWriteRaw && enable && !reset;
    assign ctrl.memWrite = memWriteRaw && enable && !reset;

endmodule

// File: execute/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
    input  logic                 Clk,
    input  instrWord             instr,
    ctrlIf.execute               ctrl,
    input  logic [dataWidth-1:0] pcPlus4,
    input  logic [dataWidth-1:0] memRdata,
    output logic                 aluZero,
    output logic [dataWidth-1:0] rsValue,
    output logic                 memWe,
    output logic [dataWidth-1:0] memAddr,
    output logic [dataWidth-1:0] memWdata
);

    logic [dataWidth-1:0]    rtValue;
    logic [dataWidth-1:0]    immExt;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    writeBack;
    logic [regAddrWidth-1:0] destReg;

    assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign aluB   = ctrl.aluSrc ? immExt : rtValue;

    assign destReg   = ctrl.jump ? linkReg : (ctrl.regDst ? instr.r.rd : instr.r.rt);
    assign writeBack = ctrl.jump ? pcPlus4 : (ctrl.memToReg ? memRdata : aluResult);

    regFile regs (
        .Clk      (Clk),
        .readAddrA(instr.r.rs),
        .readAddrB(instr.r.rt),
        .writeAddr(destReg),
        .writeEn  (ctrl.regWrite),
        .writeData(writeBack),
        .readDataA(rsValue),
        .readDataB(rtValue)
    );

    alu aluInst (
        .aluOp (ctrl.aluOp),
        .a     (rsValue),
        .b     (aluB),
        .result(aluResult),
        .zero  (aluZero)
    );

    assign memWe    = ctrl.memWrite;
    assign memAddr  = aluResult;  // Base plus offset
    assign memWdata = rtValue;

endmodule

// File: execute/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import mipsPkg::*; (
    input  logic                 Clk,
    input  logic                 writeEn,
    input  logic [dataWidth-1:0] addr,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0]     mem [memWords];
    logic [memIndexWidth-1:0] index;

    assign index = addr[memIndexWidth+1:2];  // Word address from byte address

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            mem[index] <= writeData;
        end
    end

    assign readData = mem[index];

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [aluOpWidth-1:0] aluOp,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    output logic [dataWidth-1:0]  result,
    output logic                  zero
);

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSll:  result = a << b[4:0];  // Amount from the rt value
            aluSrl:  result = a >> b[4:0];
            aluMul:  result = a * b;        // Low word of the product
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: execute/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic                    Clk,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic                    writeEn,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clk) begin
        if (writeEn && (writeAddr != '0)) begin  // Register 0 is not writable
            regs[writeAddr] <= writeData;
        end
    end

    // Entry 0 is never written, so force it
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: common/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf import mipsPkg::*; ();

    logic                  regWrite;
    logic                  regDst;    // 1 selects rd, 0 selects rt
    logic                  aluSrc;    // 1 selects the immediate
    logic                  memToReg;
    logic                  memWrite;
    logic                  branch;
    logic                  jump;      // jal
    logic                  jumpReg;   // jr
    logic [aluOpWidth-1:0] aluOp;

    modport decoder (output regWrite, regDst, aluSrc, memToReg, memWrite,
                     branch, jump, jumpReg, aluOp);
    modport fetch (input branch, jump, jumpReg);
    modport execute (input regWrite, regDst, aluSrc, memToReg, memWrite, jump, aluOp);

endinterface

// File: common/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int regCount      = 32;
    localparam int memWords      = 64;
    localparam int memIndexWidth = 6;
    localparam int aluOpWidth    = 4;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;  // jal writes the return address here

    // Primary opcodes
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opJal   = 6'b000011;

    // Funct field of the R-type group
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnMul = 6'b011000;
    localparam logic [5:0] fnJr  = 6'b001000;

    // ALU operation select
    localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 4'd3;
    localparam logic [aluOpWidth-1:0] aluXor = 4'd4;
    localparam logic [aluOpWidth-1:0] aluSll = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSrl = 4'd6;
    localparam logic [aluOpWidth-1:0] aluMul = 4'd7;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instrWord;

endpackage
